// ==== design/xaui_deskew_pkg.sv ====
package xaui_deskew_pkg;

  // ------------------------------------------------------------------------
  // Lane geometry and skew range
  // ------------------------------------------------------------------------

  // Fixed by XAUI
  localparam int num_lanes = 4;

  // Largest correctable lane skew in cycles
  localparam int max_skew = 7;
  localparam int skew_w   = 3;

  // ------------------------------------------------------------------------
  // Code groups and deskew FSM
  // ------------------------------------------------------------------------

  // K28.3 with the control flag set
  localparam logic [7:0] align_char = 8'h7C;

  // Clause 48 deskew states
  typedef enum logic [2:0] {
    loss_of_alignment = 3'd0,
    align_detect_1    = 3'd1,
    align_detect_2    = 3'd2,
    align_detect_3    = 3'd3,
    align_acquired_1  = 3'd4,
    align_acquired_2  = 3'd5,
    align_acquired_3  = 3'd6,
    align_acquired_4  = 3'd7
  } deskew_state_t;

endpackage

// ==== design/deskew_state.sv ====
`timescale 1ns/1ps

module deskew_state (
  input  xaui_deskew_pkg::deskew_state_t current_state,
  input  logic                           got_align,
  input  logic                           align_error,
  output xaui_deskew_pkg::deskew_state_t next_state,
  output logic                           aligned
);

  import xaui_deskew_pkg::*;

  // ------------------------------------------------------------------------
  // Clause 48 transition table
  // ------------------------------------------------------------------------
  always_comb begin
    case (current_state)
      loss_of_alignment: begin
        next_state = got_align ? align_detect_1 : current_state;
      end
      align_detect_1: begin
        next_state = got_align   ? align_detect_2 :
                     align_error ? loss_of_alignment : current_state;
      end
      align_detect_2: begin
        next_state = got_align   ? align_detect_3 :
                     align_error ? loss_of_alignment : current_state;
      end
      align_detect_3: begin
        next_state = got_align   ? align_acquired_1 :
                     align_error ? loss_of_alignment : current_state;
      end
      // Errors step down, good columns step back up
      align_acquired_1: begin
        next_state = align_error ? align_acquired_2 : current_state;
      end
      align_acquired_2: begin
        next_state = align_error ? align_acquired_3 :
                     got_align   ? align_acquired_1 : current_state;
      end
      align_acquired_3: begin
        next_state = align_error ? align_acquired_4 :
                     got_align   ? align_acquired_2 : current_state;
      end
      align_acquired_4: begin
        next_state = align_error ? loss_of_alignment :
                     got_align   ? align_acquired_3 : current_state;
      end
      default: begin
        next_state = loss_of_alignment;
      end
    endcase
  end

  assign aligned = current_state inside {align_acquired_1, align_acquired_2,
                                         align_acquired_3, align_acquired_4};

endmodule

// ==== design/lane_delay.sv ====
`timescale 1ns/1ps

module lane_delay (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               load,
  input  logic [xaui_deskew_pkg::skew_w-1:0] delay,
  input  logic [7:0]                         in_data,
  input  logic                               in_is_k,
  input  logic                               in_disp_err,
  output logic [7:0]                         out_data,
  output logic                               out_is_k,
  output logic                               out_disp_err
);

  import xaui_deskew_pkg::*;

  logic [skew_w-1:0] delay_q;
  logic [9:0]        cur_char;
  logic [9:0]        sel_char;
  logic [9:0]        hist [1:max_skew];

  // Character packed as {disp_err, is_k, data}
  assign cur_char = {in_disp_err, in_is_k, in_data};

  // Entry k of the history is the input from k cycles ago
  always_ff @(posedge clk) begin
    hist[1] <= cur_char;
    for (int i = 2; i <= max_skew; i++) begin
      hist[i] <= hist[i-1];
    end
  end

  always_comb begin
    if (delay_q == '0) begin
      sel_char = cur_char;
    end else begin
      sel_char = hist[delay_q];
    end
  end

  // ------------------------------------------------------------------------
  // Delay latch and output stage
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      delay_q      <= '0;
      out_data     <= '0;
      out_is_k     <= 1'b0;
      out_disp_err <= 1'b0;
    end else begin
      if (load) begin
        delay_q <= delay;
      end
      out_data     <= sel_char[7:0];
      out_is_k     <= sel_char[8];
      out_disp_err <= sel_char[9];
    end
  end

endmodule

// ==== design/skew_measure.sv ====
`timescale 1ns/1ps

module skew_measure (
  input  logic                                                           clk,
  input  logic                                                           rst_n,
  input  logic                                                           measure_en,
  input  logic [xaui_deskew_pkg::num_lanes*8-1:0]                        rx_data,
  input  logic [xaui_deskew_pkg::num_lanes-1:0]                          rx_is_k,
  output logic                                                           load,
  output logic [xaui_deskew_pkg::num_lanes*xaui_deskew_pkg::skew_w-1:0]  delays
);

  import xaui_deskew_pkg::*;

  logic [num_lanes-1:0] show_a;
  logic                 win_open;
  logic [skew_w-1:0]    win_cnt;
  logic [skew_w-1:0]    cur_off;
  logic [num_lanes-1:0] seen;
  logic [num_lanes-1:0] seen_next;
  logic [skew_w-1:0]    offs [num_lanes];
  logic [skew_w-1:0]    offs_next [num_lanes];
  logic [skew_w-1:0]    latest;
  logic                 complete;
  logic                 expire;

  // ------------------------------------------------------------------------
  // /A/ detection on the raw lanes
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      show_a[i] = measure_en && rx_is_k[i] && (rx_data[8*i +: 8] == align_char);
    end
  end

  // Offset of this cycle within the window
  assign cur_off = win_open ? win_cnt : '0;

  always_comb begin
    seen_next = win_open ? (seen | show_a) : show_a;
    for (int i = 0; i < num_lanes; i++) begin
      // First sighting wins
      offs_next[i] = (win_open && seen[i]) ? offs[i] : cur_off;
    end
  end

  assign complete = &seen_next;
  assign expire   = win_open && (win_cnt == skew_w'(max_skew)) && !complete;

  // Latest arrival among all lanes
  always_comb begin
    latest = '0;
    for (int i = 0; i < num_lanes; i++) begin
      if (offs_next[i] > latest) begin
        latest = offs_next[i];
      end
    end
  end

  // ------------------------------------------------------------------------
  // Window control and delay result
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_open <= 1'b0;
      win_cnt  <= '0;
      seen     <= '0;
      load     <= 1'b0;
      delays   <= '0;
    end else begin
      load <= 1'b0;
      if (!measure_en) begin
        win_open <= 1'b0;
        seen     <= '0;
      end else if (complete) begin
        win_open <= 1'b0;
        seen     <= '0;
        load     <= 1'b1;
        for (int i = 0; i < num_lanes; i++) begin
          delays[i*skew_w +: skew_w] <= latest - offs_next[i];
        end
      end else if (expire) begin
        // Spread beyond max_skew abandons the window
        win_open <= 1'b0;
        seen     <= '0;
      end else if (win_open || (|show_a)) begin
        win_open <= 1'b1;
        seen     <= seen_next;
        win_cnt  <= cur_off + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < num_lanes; i++) begin
      offs[i] <= offs_next[i];
    end
  end

endmodule

// ==== design/deskew_control.sv ====
`timescale 1ns/1ps

module deskew_control (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [xaui_deskew_pkg::num_lanes*8-1:0] lane_data,
  input  logic [xaui_deskew_pkg::num_lanes-1:0]   lane_is_k,
  input  logic [xaui_deskew_pkg::num_lanes-1:0]   lane_disp_err,
  output logic                                    measure_en,
  output logic                                    aligned
);

  import xaui_deskew_pkg::*;

  logic [num_lanes-1:0] lane_a;
  logic                 got_align;
  logic                 align_error;
  deskew_state_t        state;
  deskew_state_t        state_next;

  // ------------------------------------------------------------------------
  // Column checks on the realigned lanes
  // ------------------------------------------------------------------------
  always_comb begin
    for (int i = 0; i < num_lanes; i++) begin
      lane_a[i] = lane_is_k[i] && (lane_data[8*i +: 8] == align_char);
    end
  end

  assign got_align = &lane_a;

  // Partial /A/ column or any disparity error
  assign align_error = ((|lane_a) && !(&lane_a)) || (|lane_disp_err);

  deskew_state u_deskew_state (
    .current_state (state),
    .got_align     (got_align),
    .align_error   (align_error),
    .next_state    (state_next),
    .aligned       (aligned)
  );

  // ------------------------------------------------------------------------
  // State register
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= loss_of_alignment;
    end else begin
      state <= state_next;
    end
  end

  // Skew is relearned only with alignment lost
  assign measure_en = (state == loss_of_alignment);

endmodule

// ==== design/xaui_deskew.sv ====
`timescale 1ns/1ps

module xaui_deskew (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  logic [xaui_deskew_pkg::num_lanes*8-1:0] rx_data,
  input  logic [xaui_deskew_pkg::num_lanes-1:0]   rx_is_k,
  input  logic [xaui_deskew_pkg::num_lanes-1:0]   rx_disp_err,
  output logic [xaui_deskew_pkg::num_lanes*8-1:0] out_data,
  output logic [xaui_deskew_pkg::num_lanes-1:0]   out_is_k,
  output logic [xaui_deskew_pkg::num_lanes-1:0]   out_disp_err,
  output logic                                    aligned
);

  import xaui_deskew_pkg::*;

  logic                          load;
  logic [num_lanes*skew_w-1:0]   delays;
  logic                          measure_en;

  // ------------------------------------------------------------------------
  // Per-lane delay lines
  // ------------------------------------------------------------------------
  for (genvar i = 0; i < num_lanes; i++) begin : g_lane
    lane_delay u_lane_delay (
      .clk          (clk),
      .rst_n        (rst_n),
      .load         (load),
      .delay        (delays[i*skew_w +: skew_w]),
      .in_data      (rx_data[8*i +: 8]),
      .in_is_k      (rx_is_k[i]),
      .in_disp_err  (rx_disp_err[i]),
      .out_data     (out_data[8*i +: 8]),
      .out_is_k     (out_is_k[i]),
      .out_disp_err (out_disp_err[i])
    );
  end

  // Skew is measured on the raw lanes
  skew_measure u_skew_measure (
    .clk        (clk),
    .rst_n      (rst_n),
    .measure_en (measure_en),
    .rx_data    (rx_data),
    .rx_is_k    (rx_is_k),
    .load       (load),
    .delays     (delays)
  );

  // Alignment is judged on the realigned lanes
  deskew_control u_deskew_control (
    .clk           (clk),
    .rst_n         (rst_n),
    .lane_data     (out_data),
    .lane_is_k     (out_is_k),
    .lane_disp_err (out_disp_err),
    .measure_en    (measure_en),
    .aligned       (aligned)
  );

endmodule

// ==== tests/tb_xaui_deskew.sv ====
`timescale 1ns/1ps

module tb_xaui_deskew;

  import xaui_deskew_pkg::*;

  logic                   clk;
  logic                   rst_n;
  logic [num_lanes*8-1:0] rx_data;
  logic [num_lanes-1:0]   rx_is_k;
  logic [num_lanes-1:0]   rx_disp_err;
  logic [num_lanes*8-1:0] out_data;
  logic [num_lanes-1:0]   out_is_k;
  logic [num_lanes-1:0]   out_disp_err;
  logic                   aligned;

  // Reference characters as {disp_err, is_k, data}
  logic [9:0]     ref_mem [0:4095];
  logic [31:0]    prev_rx;
  int             cyc;
  int             skew [num_lanes];
  int             smax;
  int             gap_cnt;
  int             err_cnt;
  bit             a_sent;
  bit             tracking;
  bit             passthru_chk;
  deskew_state_t  model_state;

  xaui_deskew UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .rx_data      (rx_data),
    .rx_is_k      (rx_is_k),
    .rx_disp_err  (rx_disp_err),
    .out_data     (out_data),
    .out_is_k     (out_is_k),
    .out_disp_err (out_disp_err),
    .aligned      (aligned)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ------------------------------------------------------------------------
  // Reference model
  // ------------------------------------------------------------------------
  function automatic bit is_align(logic [9:0] ch);
    return ch[8] && (ch[7:0] == align_char);
  endfunction

  // Detect states count up on /A/, acquired states count errors
  function automatic deskew_state_t model_next(deskew_state_t s, bit got, bit err);
    int v;
    v = int'(s);
    if (v == 0) return got ? deskew_state_t'(1) : s;
    if (v < 4) return got ? deskew_state_t'(v + 1) : (err ? deskew_state_t'(0) : s);
    if (err) return (v == 7) ? deskew_state_t'(0) : deskew_state_t'(v + 1);
    if (got && v > 4) return deskew_state_t'(v - 1);
    return s;
  endfunction

  task automatic stop_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic report_value(string name, logic [31:0] got, logic [31:0] exp);
    $display("ERR %s got=%h expected=%h", name, got, exp);
    stop_run();
  endtask

  task automatic report_timeout(string what);
    $display("Timed out waiting for %s", what);
    stop_run();
  endtask

  // ------------------------------------------------------------------------
  // Skewed lane stimulus
  // ------------------------------------------------------------------------
  always @(posedge clk) begin
    logic [9:0] ch;
    if (gap_cnt == 0) begin
      ch = {1'b0, 1'b1, align_char};
      gap_cnt = 15 + $urandom_range(15);
      a_sent = 1'b1;
    end else begin
      ch = {1'b0, 1'b0, 8'($urandom)};
      gap_cnt--;
      a_sent = 1'b0;
      if (err_cnt > 0) begin
        ch[9] = 1'b1;
        err_cnt--;
      end
    end
    ref_mem[cyc & 4095] = ch;
    prev_rx <= rx_data;
    for (int n = 0; n < num_lanes; n++) begin
      ch = ref_mem[(cyc - skew[n]) & 4095];
      rx_data[8*n +: 8] <= ch[7:0];
      rx_is_k[n]        <= ch[8];
      rx_disp_err[n]    <= ch[9];
    end
    cyc++;
  end

  // ------------------------------------------------------------------------
  // Output checks at mid-cycle
  // ------------------------------------------------------------------------
  always @(negedge clk) begin
    logic [9:0] e;
    if (passthru_chk) begin
      assert (aligned == 1'b0) else report_value("aligned", aligned, 0);
      assert (out_data == prev_rx) else report_value("out_data", out_data, prev_rx);
    end
    if (tracking) begin
      // Latency is the largest skew plus one register stage
      e = ref_mem[(cyc - 2 - smax) & 4095];
      for (int n = 0; n < num_lanes; n++) begin
        assert ({out_disp_err[n], out_is_k[n], out_data[8*n +: 8]} == e)
          else report_value($sformatf("out lane %0d", n),
                            {out_disp_err[n], out_is_k[n], out_data[8*n +: 8]}, e);
      end
      assert (aligned == (model_state >= align_acquired_1))
        else report_value("aligned", aligned, model_state >= align_acquired_1);
      model_state = model_next(model_state, is_align(e), e[9]);
    end
  end

  task automatic pick_skews();
    for (int n = 0; n < num_lanes; n++) begin
      skew[n] = $urandom_range(max_skew, 0);
    end
  endtask

  task automatic start_tracking();
    smax = 0;
    for (int n = 0; n < num_lanes; n++) begin
      if (skew[n] > smax) smax = skew[n];
    end
    model_state = align_acquired_1;
    tracking = 1'b1;
  endtask

  task automatic wait_aligned(int limit, bit level);
    int n;
    n = 0;
    while (aligned !== level) begin
      @(negedge clk);
      n++;
      if (n > limit) report_timeout(level ? "aligned to rise" : "aligned to fall");
    end
  endtask

  // One /A/ column to measure, then four more to reach acquired
  task automatic wait_acquire(int max_cols);
    int n;
    int cols;
    n = 0;
    cols = 0;
    while (aligned !== 1'b1) begin
      @(negedge clk);
      n++;
      if (a_sent) begin
        cols++;
      end
      if (cols > max_cols || n > 32 * (max_cols + 1)) begin
        report_timeout("aligned to rise");
      end
    end
  endtask

  task automatic wait_ref_a();
    int n;
    n = 0;
    while (!a_sent) begin
      @(negedge clk);
      n++;
      if (n > 40) report_timeout("an /A/ column in the stimulus");
    end
  endtask

  task automatic wait_a_columns(int count);
    repeat (count) begin
      @(negedge clk);
      wait_ref_a();
    end
  endtask

  // Each burst starts right after an /A/ column and holds no /A/
  task automatic inject_errors(int count);
    @(negedge clk);
    wait_ref_a();
    err_cnt = count;
  endtask

  initial begin
    void'($urandom(32'he8d6c528));
    rst_n        = 1'b0;
    rx_data      = '0;
    rx_is_k      = '0;
    rx_disp_err  = '0;
    prev_rx      = '0;
    cyc          = 0;
    gap_cnt      = 30;
    err_cnt      = 0;
    a_sent       = 1'b0;
    tracking     = 1'b0;
    passthru_chk = 1'b0;
    model_state  = loss_of_alignment;
    for (int i = 0; i < 4096; i++) begin
      ref_mem[i] = '0;
    end
    pick_skews();
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    @(negedge clk);
    passthru_chk = 1'b1;
    repeat (10) @(negedge clk);
    passthru_chk = 1'b0;

    wait_acquire(5);
    start_tracking();
    wait_a_columns(4);
    for (int k = 1; k <= 3; k++) begin
      inject_errors(k);
      wait_a_columns(4);
    end
    assert (aligned == 1'b1) else report_value("aligned", aligned, 1);

    inject_errors(4);
    wait_aligned(64, 1'b0);
    tracking = 1'b0;
    pick_skews();
    wait_acquire(5);
    start_tracking();
    wait_a_columns(6);

    $display("Everything OK");
    $finish;
  end

endmodule

// ==== xaui_deskew.f ====
design/xaui_deskew_pkg.sv
design/deskew_state.sv
design/lane_delay.sv
design/skew_measure.sv
design/deskew_control.sv
design/xaui_deskew.sv
tests/tb_xaui_deskew.sv
